// ==== source/snakes_defines.svh ====
`ifndef SNAKES_DEFINES_SVH
`define SNAKES_DEFINES_SVH

// last square on the board
`define SNAKES_BOARD_LAST 100

// faces on the die
`define SNAKES_DICE_FACES 6

// square number 0..100
`define SNAKES_POSITION_WIDTH 7

// die value 0..6
`define SNAKES_DICE_WIDTH 3

// one seven-segment digit
`define SNAKES_SEGMENT_WIDTH 7

`endif

// ==== source/snakesPkg.sv ====
`default_nettype none

`include "snakes_defines.svh"

package snakesPkg;

	// square number, 0 before the game starts
	typedef logic [`SNAKES_POSITION_WIDTH-1:0] position_t;

	// 0 means no roll yet
	typedef logic [`SNAKES_DICE_WIDTH-1:0] diceValue_t;

	typedef enum logic
	{
		playerOne,
		playerTwo
	} playerId_t;

	typedef struct packed
	{
		logic beginGame; // both players to square 1
		logic move; // one-cycle strobe
		playerId_t player; // who moves
	} moveCommand_t;

	typedef struct packed
	{
		position_t positionOne;
		position_t positionTwo;
	} boardPositions_t;

endpackage

`default_nettype wire

// ==== source/gameControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module gameControl import snakesPkg::*; (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic [2:0] KEY,
	output moveCommand_t command,
	output logic rollStrobe,
	output logic quit
);

	typedef enum logic [3:0]
	{
		startWait,
		startHeld,
		gameBegin,
		oneWait,
		oneHeld,
		oneMove,
		twoWait,
		twoHeld,
		twoMove
	} turnState_t;

	logic [2:0] keySync1;
	logic [2:0] keySync2;
	logic play;
	logic start;
	turnState_t state;
	turnState_t nextState;

	// keys are active low, flip before sync
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
		begin
			keySync1 <= '0;
			keySync2 <= '0;
		end
		else
		begin
			keySync1 <= ~KEY;
			keySync2 <= keySync1;
		end
	end

	assign play = keySync2[0];
	assign quit = keySync2[1];
	assign start = keySync2[2];

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			state <= startWait;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state;
		case (state)
			startWait: if (start) nextState = startHeld;
			startHeld: if (!start) nextState = gameBegin;
			gameBegin: nextState = oneWait;
			oneWait: if (play) nextState = oneHeld;
			oneHeld: if (!play) nextState = oneMove; // act on release
			oneMove: nextState = twoWait;
			twoWait: if (play) nextState = twoHeld;
			twoHeld: if (!play) nextState = twoMove;
			twoMove: nextState = oneWait;
			default: nextState = startWait;
		endcase
		if (quit)
			nextState = startWait; // quit wins from any state
	end

	always_comb
	begin
		command.beginGame = (state == gameBegin);
		command.move = (state == oneMove) || (state == twoMove);
		command.player = (state == twoMove) ? playerTwo : playerOne;
		rollStrobe = play && ((state == oneWait) || (state == twoWait)); // die sampled on press
	end

	assert property (@(posedge CLOCK_50) disable iff (reset)
		!(command.move && command.beginGame))
		else $error("move and beginGame high together");

endmodule

`default_nettype wire

// ==== source/diceRoller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakes_defines.svh"

module diceRoller import snakesPkg::*; (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic quit,
	input wire logic rollStrobe,
	output diceValue_t roll
);

	diceValue_t faceCount;

	// spins far faster than any key press, so the face is effectively random
	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			faceCount <= diceValue_t'(1);
		else if (faceCount == diceValue_t'(`SNAKES_DICE_FACES))
			faceCount <= diceValue_t'(1);
		else
			faceCount <= faceCount + diceValue_t'(1);
	end

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			roll <= '0;
		else if (quit)
			roll <= '0; // back to no roll
		else if (rollStrobe)
			roll <= faceCount;
	end

	assert property (@(posedge CLOCK_50) disable iff (reset)
		roll <= diceValue_t'(`SNAKES_DICE_FACES))
		else $error("roll above the last die face");

endmodule

`default_nettype wire

// ==== source/playerMover.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakes_defines.svh"

module playerMover import snakesPkg::*; (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire moveCommand_t command,
	input wire diceValue_t roll,
	output boardPositions_t positions
);

	position_t currentPosition;
	position_t target;
	position_t landing;

	// ladder feet go up and snake heads go down
	function automatic position_t jumpTarget(input position_t square);
		case (square)
			7'd8: jumpTarget = 7'd14;
			7'd21: jumpTarget = 7'd40;
			7'd26: jumpTarget = 7'd35;
			7'd42: jumpTarget = 7'd62;
			7'd43: jumpTarget = 7'd44;
			7'd47: jumpTarget = 7'd67;
			7'd48: jumpTarget = 7'd49;
			7'd51: jumpTarget = 7'd71;
			7'd53: jumpTarget = 7'd54;
			7'd58: jumpTarget = 7'd59;
			7'd63: jumpTarget = 7'd64;
			7'd68: jumpTarget = 7'd69;
			7'd74: jumpTarget = 7'd86;
			7'd87: jumpTarget = 7'd94;
			7'd18: jumpTarget = 7'd6;
			7'd24: jumpTarget = 7'd19;
			7'd34: jumpTarget = 7'd11;
			7'd66: jumpTarget = 7'd46;
			7'd93: jumpTarget = 7'd73;
			7'd97: jumpTarget = 7'd86;
			7'd99: jumpTarget = 7'd61;
			default: jumpTarget = square;
		endcase
	endfunction

	always_comb
	begin
		currentPosition = (command.player == playerOne) ? positions.positionOne
			: positions.positionTwo;
		target = currentPosition + position_t'(roll); // max 106 fits in 7 bits
		if (target > position_t'(`SNAKES_BOARD_LAST))
			landing = currentPosition; // overshoot stays put
		else
			landing = jumpTarget(target);
	end

	always_ff @(posedge CLOCK_50 or posedge reset)
	begin
		if (reset)
			positions <= '0;
		else if (command.beginGame)
		begin
			positions.positionOne <= position_t'(1);
			positions.positionTwo <= position_t'(1);
		end
		else if (command.move)
		begin
			if (command.player == playerOne)
				positions.positionOne <= landing;
			else
				positions.positionTwo <= landing;
		end
	end

	assert property (@(posedge CLOCK_50) disable iff (reset)
		positions.positionOne <= position_t'(`SNAKES_BOARD_LAST)
		&& positions.positionTwo <= position_t'(`SNAKES_BOARD_LAST))
		else $error("position past the last square");

endmodule

`default_nettype wire

// ==== source/scoreDisplay.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakes_defines.svh"

module scoreDisplay import snakesPkg::*; (
	input wire boardPositions_t positions,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX0,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX1,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX2,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX3,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX4,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX5
);

	// decimal digit at a given place, place is 1, 10 or 100
	function automatic position_t digitAt(input position_t value, input position_t place);
		digitAt = (value / place) % 7'd10;
	endfunction

	// active-low segments, gfedcba
	function automatic logic [`SNAKES_SEGMENT_WIDTH-1:0] toSegments(input position_t digit);
		case (digit)
			7'd0: toSegments = 7'b100_0000;
			7'd1: toSegments = 7'b111_1001;
			7'd2: toSegments = 7'b010_0100;
			7'd3: toSegments = 7'b011_0000;
			7'd4: toSegments = 7'b001_1001;
			7'd5: toSegments = 7'b001_0010;
			7'd6: toSegments = 7'b000_0010;
			7'd7: toSegments = 7'b111_1000;
			7'd8: toSegments = 7'b000_0000;
			7'd9: toSegments = 7'b001_1000;
			default: toSegments = 7'b111_1111; // blank
		endcase
	endfunction

	// player 1 on the right
	assign HEX0 = toSegments(digitAt(positions.positionOne, 7'd1));
	assign HEX1 = toSegments(digitAt(positions.positionOne, 7'd10));
	assign HEX2 = toSegments(digitAt(positions.positionOne, 7'd100));

	assign HEX3 = toSegments(digitAt(positions.positionTwo, 7'd1));
	assign HEX4 = toSegments(digitAt(positions.positionTwo, 7'd10));
	assign HEX5 = toSegments(digitAt(positions.positionTwo, 7'd100));

endmodule

`default_nettype wire

// ==== source/SnakesAndLadders.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakes_defines.svh"

module SnakesAndLadders (
	input wire logic CLOCK_50,
	input wire logic reset,
	input wire logic [2:0] KEY, // play, quit, start
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX0,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX1,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX2,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX3,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX4,
	output logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX5
);

	snakesPkg::moveCommand_t command;
	snakesPkg::diceValue_t roll;
	snakesPkg::boardPositions_t positions;
	logic rollStrobe;
	logic quit;

	gameControl control0 (
		.CLOCK_50(CLOCK_50), .reset(reset), .KEY(KEY),
		.command(command), .rollStrobe(rollStrobe), .quit(quit)
	);

	diceRoller dice0 (
		.CLOCK_50(CLOCK_50), .reset(reset), .quit(quit),
		.rollStrobe(rollStrobe), .roll(roll)
	);

	playerMover mover0 (
		.CLOCK_50(CLOCK_50), .reset(reset), .command(command),
		.roll(roll), .positions(positions)
	);

	scoreDisplay display0 (
		.positions(positions),
		.HEX0(HEX0), .HEX1(HEX1), .HEX2(HEX2),
		.HEX3(HEX3), .HEX4(HEX4), .HEX5(HEX5)
	);

endmodule

`default_nettype wire

// ==== testbench/clockGen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clockGen #(
	parameter int period = 40,
	parameter int resetCycles = 5
) (
	output logic CLOCK_50,
	output logic powerReset
);

	initial
	begin
		CLOCK_50 = 1'b0;
		forever #(period / 2) CLOCK_50 = ~CLOCK_50;
	end

	initial
	begin
		powerReset = 1'b1;
		repeat (resetCycles) @(posedge CLOCK_50);
		powerReset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== testbench/tb_SnakesAndLadders.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "snakes_defines.svh"

module tb_SnakesAndLadders;

	localparam logic [31:0] lfsrSeed = 32'hd8050e7f;
	localparam int settleLimit = 12; // HEX follows a release within 5 cycles
	localparam int resetLimit = 20;
	localparam int turnCount = 40;
	localparam logic [1:0] playKey = 2'd0;
	localparam logic [1:0] quitKey = 2'd1;
	localparam logic [1:0] startKey = 2'd2;

	logic CLOCK_50;
	logic powerReset;
	logic testReset;
	logic reset;
	logic [2:0] KEY;
	logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX0;
	logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX1;
	logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX2;
	logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX3;
	logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX4;
	logic [`SNAKES_SEGMENT_WIDTH-1:0] HEX5;
	logic [31:0] lfsrState;
	int errorCount;
	int testStartErrors;
	int testsRun;
	int testsFailed;
	bit jumpSeen;
	bit staySeen;

	assign reset = powerReset | testReset;

	clockGen clock0 (.CLOCK_50(CLOCK_50), .powerReset(powerReset));

	SnakesAndLadders dut0 (
		.CLOCK_50(CLOCK_50), .reset(reset), .KEY(KEY),
		.HEX0(HEX0), .HEX1(HEX1), .HEX2(HEX2),
		.HEX3(HEX3), .HEX4(HEX4), .HEX5(HEX5)
	);

	// fibonacci with taps 32 22 2 1
	function automatic int nextBit();
		lfsrState = {lfsrState[30:0],
			lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
		return int'(lfsrState[0]);
	endfunction

	function automatic int holdCycles();
		int bits;
		bits = 0;
		for (int i = 0; i < 4; i++)
			bits = (bits << 1) | nextBit();
		return 3 + bits; // 3 to 18
	endfunction

	function automatic int jumpOf(input int square);
		case (square)
			8: return 14;
			21: return 40;
			26: return 35;
			42: return 62;
			43: return 44;
			47: return 67;
			48: return 49;
			51: return 71;
			53: return 54;
			58: return 59;
			63: return 64;
			68: return 69;
			74: return 86;
			87: return 94;
			18: return 6;
			24: return 19;
			34: return 11;
			66: return 46;
			93: return 73;
			97: return 86;
			99: return 61;
			default: return square;
		endcase
	endfunction

	// is toSquare one of the results over all faces
	function automatic bit legalMove(input int fromSquare, input int toSquare);
		bit found;
		int target;
		found = 1'b0;
		for (int face = 1; face <= `SNAKES_DICE_FACES; face++)
		begin
			target = fromSquare + face;
			if (target > `SNAKES_BOARD_LAST)
				found = found || (toSquare == fromSquare); // overshoot stays
			else
				found = found || (toSquare == jumpOf(target));
		end
		return found;
	endfunction

	task automatic pressRelease(input logic [1:0] keyIndex);
		int pressCycles;
		int releaseCycles;
		pressCycles = holdCycles();
		releaseCycles = holdCycles();
		@(posedge CLOCK_50);
		KEY[keyIndex] <= 1'b0; // active low
		repeat (pressCycles) @(posedge CLOCK_50);
		KEY[keyIndex] <= 1'b1;
		repeat (releaseCycles) @(posedge CLOCK_50);
	endtask

	// active-low gfedcba back to a digit
	task automatic decodeDigit(input int index, input logic [6:0] segments, output int digit);
		case (segments)
			7'b100_0000: digit = 0;
			7'b111_1001: digit = 1;
			7'b010_0100: digit = 2;
			7'b011_0000: digit = 3;
			7'b001_1001: digit = 4;
			7'b001_0010: digit = 5;
			7'b000_0010: digit = 6;
			7'b111_1000: digit = 7;
			7'b000_0000: digit = 8;
			7'b001_1000: digit = 9;
			default: digit = -1;
		endcase
		assert (digit >= 0)
		else
		begin
			$display("HEX%0d shows a pattern that is not a decimal digit at time %0t",
				index, $time);
			errorCount++;
			digit = 0;
		end
	endtask

	task automatic readPositions(output int positionOne, output int positionTwo);
		int digit0;
		int digit1;
		int digit2;
		int digit3;
		int digit4;
		int digit5;
		@(negedge CLOCK_50); // away from the clock edge
		decodeDigit(0, HEX0, digit0);
		decodeDigit(1, HEX1, digit1);
		decodeDigit(2, HEX2, digit2);
		decodeDigit(3, HEX3, digit3);
		decodeDigit(4, HEX4, digit4);
		decodeDigit(5, HEX5, digit5);
		positionOne = 100 * digit2 + 10 * digit1 + digit0;
		positionTwo = 100 * digit5 + 10 * digit4 + digit3;
	endtask

	task automatic checkValue(input string what, input int actual, input int expected);
		assert (actual == expected)
		else
		begin
			$display("FAILED at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
			errorCount++;
		end
	endtask

	task automatic waitForChange(input int beforeOne, input int beforeTwo,
		output int afterOne, output int afterTwo);
		int count;
		bit changed;
		readPositions(afterOne, afterTwo);
		changed = (afterOne != beforeOne) || (afterTwo != beforeTwo);
		for (count = 0; count < settleLimit && !changed; count++)
		begin
			readPositions(afterOne, afterTwo);
			changed = (afterOne != beforeOne) || (afterTwo != beforeTwo);
		end
	endtask

	task automatic waitForPositions(input int expectOne, input int expectTwo);
		int one;
		int two;
		int count;
		readPositions(one, two);
		for (count = 0; count < settleLimit && (one != expectOne || two != expectTwo); count++)
			readPositions(one, two);
		checkValue("player 1 position", one, expectOne);
		checkValue("player 2 position", two, expectTwo);
	endtask

	task automatic takeTurn(input int mover);
		int beforeOne;
		int beforeTwo;
		int afterOne;
		int afterTwo;
		int fromSquare;
		int toSquare;
		readPositions(beforeOne, beforeTwo);
		pressRelease(playKey);
		waitForChange(beforeOne, beforeTwo, afterOne, afterTwo);
		fromSquare = (mover == 1) ? beforeOne : beforeTwo;
		toSquare = (mover == 1) ? afterOne : afterTwo;
		if (mover == 1)
			checkValue("player 2 on a player 1 turn", afterTwo, beforeTwo);
		else
			checkValue("player 1 on a player 2 turn", afterOne, beforeOne);
		assert (legalMove(fromSquare, toSquare))
		else
		begin
			$display("FAILED at %0t: player %0d went from %0d to %0d, no roll gives that",
				$time, mover, fromSquare, toSquare);
			errorCount++;
		end
		if (toSquare == fromSquare)
			staySeen = 1'b1;
		else if (toSquare < fromSquare || toSquare > fromSquare + `SNAKES_DICE_FACES)
			jumpSeen = 1'b1;
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errorCount == testStartErrors)
			$display("test %0d %s: ok", testsRun, name);
		else
		begin
			testsFailed++;
			$display("test %0d %s: %0d errors", testsRun, name, errorCount - testStartErrors);
		end
		testStartErrors = errorCount;
	endtask

	task automatic resetAndIdleTest();
		int one;
		int two;
		waitForPositions(0, 0);
		pressRelease(playKey); // no game yet
		waitForChange(0, 0, one, two);
		checkValue("player 1 after early play", one, 0);
		checkValue("player 2 after early play", two, 0);
		finishTest("reset and play before start");
	endtask

	task automatic startTest();
		pressRelease(startKey);
		waitForPositions(1, 1);
		finishTest("start shows 001 for both");
	endtask

	task automatic firstTurnsTest();
		takeTurn(1);
		takeTurn(2);
		finishTest("first turns");
	endtask

	task automatic alternatingTurnsTest();
		jumpSeen = 1'b0;
		staySeen = 1'b0;
		for (int turn = 0; turn < turnCount; turn++)
			takeTurn(turn % 2 + 1);
		finishTest($sformatf("%0d turns, jump seen %0d, stay seen %0d",
			turnCount, jumpSeen, staySeen));
	endtask

	task automatic quitRestartTest();
		pressRelease(quitKey);
		pressRelease(startKey);
		waitForPositions(1, 1);
		takeTurn(1); // player 1 leads again
		finishTest("quit and start again");
	endtask

	task automatic midGameResetTest();
		int one;
		int two;
		@(posedge CLOCK_50);
		testReset <= 1'b1;
		repeat (2) @(posedge CLOCK_50);
		testReset <= 1'b0;
		waitForPositions(0, 0);
		pressRelease(playKey);
		waitForChange(0, 0, one, two);
		checkValue("player 1 after play in reset game", one, 0);
		checkValue("player 2 after play in reset game", two, 0);
		pressRelease(startKey);
		waitForPositions(1, 1);
		finishTest("reset mid-game");
	endtask

	initial
	begin
		int count;
		KEY = 3'b111;
		testReset = 1'b0;
		lfsrState = lfsrSeed;
		@(posedge CLOCK_50);
		for (count = 0; count < resetLimit && reset; count++)
			@(posedge CLOCK_50);
		assert (!reset)
		else
		begin
			$display("reset was still high after %0d cycles", resetLimit);
			errorCount++;
		end
		resetAndIdleTest();
		startTest();
		firstTurnsTest();
		alternatingTurnsTest();
		quitRestartTest();
		midGameResetTest();
		$display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errorCount);
		if (errorCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

// ==== SnakesAndLadders.f ====
+incdir+source
source/snakesPkg.sv
source/gameControl.sv
source/diceRoller.sv
source/playerMover.sv
source/scoreDisplay.sv
source/SnakesAndLadders.sv
testbench/clockGen.sv
testbench/tb_SnakesAndLadders.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the snakes-and-ladders testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_SnakesAndLadders \
	-f SnakesAndLadders.f \
	-o simSnakes

./obj_dir/simSnakes | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	exit 1
fi
